// File: Makefile
# Verilator build for the display engine testbench.
VERILATOR ?= verilator
TOP       ?= tb_display_engine
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard logic/*.sv logic/*.svh testbench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/cmd_dispatch.sv
// **********************************************************
// Command port handshake, opcode decode and unit start.
// **********************************************************
`timescale 1ns/10ps

module cmd_dispatch (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  fb_pkg::opcode_t   cmd_op,
    input  fb_pkg::xcoord_t   cmd_x,
    input  fb_pkg::xcoord_t   cmd_width,
    input  fb_pkg::ycoord_t   cmd_y,
    input  fb_pkg::ycoord_t   cmd_height,
    input  fb_pkg::color_t    cmd_color,
    input  logic              fill_busy,
    input  logic              pix_busy,
    output logic              fill_start,
    output logic              pix_start,
    output logic              pix_write,
    output fb_pkg::xcoord_t   x,
    output fb_pkg::ycoord_t   y,
    output fb_pkg::xcoord_t   width,
    output fb_pkg::ycoord_t   height,
    output fb_pkg::color_t    color
);

    logic fill_hold;
    logic pix_hold;
    logic take;

    // A unit is not yet busy in the cycle of its start pulse.
    assign fill_hold = fill_busy || fill_start;
    assign pix_hold  = pix_busy || pix_start;

    always_comb begin
        case (cmd_op)
            fb_pkg::OP_FILL: cmd_ready = !fill_hold;
            fb_pkg::OP_PLOT: cmd_ready = !pix_hold;
            fb_pkg::OP_READ: cmd_ready = !pix_hold && !fill_hold;  // Wait for a running fill.
            default:         cmd_ready = 1'b0;
        endcase
    end

    assign take = cmd_valid && cmd_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            fill_start <= 1'b0;
            pix_start  <= 1'b0;
        end else begin
            fill_start <= take && (cmd_op == fb_pkg::OP_FILL);
            pix_start  <= take && (cmd_op != fb_pkg::OP_FILL);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pix_write <= (cmd_op == fb_pkg::OP_PLOT);
            x         <= cmd_x;
            y         <= cmd_y;
            width     <= cmd_width;
            height    <= cmd_height;
            color     <= cmd_color;
        end
    end

    a_read_after_fill: assert property (@(posedge clk) disable iff (reset)
        pix_start && !pix_write |-> !fill_busy);

endmodule

// File: logic/display_engine.sv
// **********************************************************
// Display command engine top: dispatcher, fill and pixel
// units, memory arbiter and frame memory.
// **********************************************************
`timescale 1ns/10ps

module display_engine (
    input  logic              clk,
    input  logic              reset,
    input  logic              cmd_valid,
    output logic              cmd_ready,
    input  fb_pkg::opcode_t   cmd_op,
    input  fb_pkg::xcoord_t   cmd_x,
    input  fb_pkg::ycoord_t   cmd_y,
    input  fb_pkg::xcoord_t   cmd_width,
    input  fb_pkg::ycoord_t   cmd_height,
    input  fb_pkg::color_t    cmd_color,
    output logic              rsp_valid,
    output fb_pkg::color_t    rsp_color,
    input  logic              rsp_ready,
    output logic              fill_done
);

    logic              fill_start, pix_start, pix_write;
    logic              fill_busy, pix_busy;
    fb_pkg::xcoord_t   lat_x, lat_width;
    fb_pkg::ycoord_t   lat_y, lat_height;
    fb_pkg::color_t    lat_color;

    logic              fill_req, fill_we, fill_gnt;
    fb_pkg::addr_t     fill_addr;
    logic [7:0]        fill_wdata;
    logic              pix_req, pix_we, pix_gnt;
    fb_pkg::addr_t     pix_addr;
    logic [7:0]        pix_wdata;

    logic              mem_en, mem_we;
    fb_pkg::addr_t     mem_addr;
    logic [7:0]        mem_wdata, mem_rdata;

    cmd_dispatch u_dispatch (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
        .cmd_x(cmd_x), .cmd_width(cmd_width), .cmd_y(cmd_y), .cmd_height(cmd_height),
        .cmd_color(cmd_color), .fill_busy(fill_busy), .pix_busy(pix_busy),
        .fill_start(fill_start), .pix_start(pix_start), .pix_write(pix_write),
        .x(lat_x), .y(lat_y), .width(lat_width), .height(lat_height), .color(lat_color)
    );

    fill_area u_fill (
        .clk(clk), .reset(reset), .fill_start(fill_start),
        .x1(lat_x), .y1(lat_y), .width(lat_width), .height(lat_height), .color(lat_color),
        .req(fill_req), .we(fill_we), .addr(fill_addr), .wdata(fill_wdata), .gnt(fill_gnt),
        .busy(fill_busy), .done(fill_done)
    );

    pixel_access u_pixel (
        .clk(clk), .reset(reset), .pix_start(pix_start), .pix_write(pix_write),
        .x(lat_x), .y(lat_y), .color(lat_color),
        .req(pix_req), .we(pix_we), .addr(pix_addr), .wdata(pix_wdata), .gnt(pix_gnt),
        .rdata(mem_rdata), .busy(pix_busy),
        .rsp_valid(rsp_valid), .rsp_color(rsp_color), .rsp_ready(rsp_ready)
    );

    fb_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .fill_req(fill_req), .fill_we(fill_we), .fill_addr(fill_addr),
        .fill_wdata(fill_wdata), .fill_gnt(fill_gnt),
        .pix_req(pix_req), .pix_we(pix_we), .pix_addr(pix_addr),
        .pix_wdata(pix_wdata), .pix_gnt(pix_gnt),
        .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

    frame_ram u_ram (
        .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

// File: logic/fb_arbiter.sv
// **********************************************************
// Round-robin arbiter between the fill unit and the pixel
// unit for the single frame memory port.
// **********************************************************
`timescale 1ns/10ps

module fb_arbiter (
    input  logic            clk,
    input  logic            reset,
    input  logic            fill_req,
    input  logic            fill_we,
    input  fb_pkg::addr_t   fill_addr,
    input  logic [7:0]      fill_wdata,
    output logic            fill_gnt,
    input  logic            pix_req,
    input  logic            pix_we,
    input  fb_pkg::addr_t   pix_addr,
    input  logic [7:0]      pix_wdata,
    output logic            pix_gnt,
    output logic            mem_en,
    output logic            mem_we,
    output fb_pkg::addr_t   mem_addr,
    output logic [7:0]      mem_wdata
);

    logic last_pix;                                  // Pixel unit won the last grant.

    // On contention the unit that did not win last time goes first.
    assign fill_gnt = fill_req && (!pix_req || last_pix);
    assign pix_gnt  = pix_req && (!fill_req || !last_pix);

    always_ff @(posedge clk) begin
        if (reset) begin
            last_pix <= 1'b0;
        end else if (fill_gnt) begin
            last_pix <= 1'b0;
        end else if (pix_gnt) begin
            last_pix <= 1'b1;
        end
    end

    assign mem_en    = fill_gnt || pix_gnt;
    assign mem_we    = fill_gnt ? fill_we : (pix_gnt && pix_we);
    assign mem_addr  = fill_gnt ? fill_addr : pix_addr;
    assign mem_wdata = fill_gnt ? fill_wdata : pix_wdata;

    // A unit denied under contention wins the next cycle if it still asks.
    a_fill_wait: assert property (@(posedge clk) disable iff (reset)
        (fill_req && !fill_gnt) |=> (!fill_req || fill_gnt));
    a_pix_wait: assert property (@(posedge clk) disable iff (reset)
        (pix_req && !pix_gnt) |=> (!pix_req || pix_gnt));

endmodule

// File: logic/fb_defines.svh
// **********************************************************
// Frame buffer geometry: screen size, bytes per pixel and
// the index widths derived from them.
// **********************************************************
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

`define FB_WIDTH      16                                       // Pixels per row.
`define FB_HEIGHT     12                                       // Rows on screen.
`define FB_BPP        3                                        // Bytes per pixel.
`define FB_BYTES      (`FB_WIDTH * `FB_HEIGHT * `FB_BPP)       // 576 bytes of frame memory.

`define FB_ADDR_BITS  10                                       // Byte address width.
`define FB_X_BITS     5                                        // Wide enough for a full-row width.
`define FB_Y_BITS     4
`define FB_SEL_BITS   2                                        // Byte index within a pixel.

`endif

// File: logic/fb_pkg.sv
// **********************************************************
// Display engine types: opcodes, FSM states, coordinates,
// colour and the shared byte address rule.
// **********************************************************
`include "fb_defines.svh"

package fb_pkg;

    typedef enum logic [1:0] {
        OP_FILL = 2'd0,
        OP_PLOT = 2'd1,
        OP_READ = 2'd2
    } opcode_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_WRITE,
        FILL_DONE
    } fill_state_t;

    typedef enum logic [1:0] {
        PIX_IDLE,
        PIX_ACCESS,
        PIX_WAIT_DATA,
        PIX_RESPOND
    } pix_state_t;

    typedef logic [`FB_X_BITS-1:0]      xcoord_t;
    typedef logic [`FB_Y_BITS-1:0]      ycoord_t;
    typedef logic [`FB_BPP*8-1:0]       color_t;
    typedef logic [`FB_ADDR_BITS-1:0]   addr_t;

    // Byte sel of pixel (x, y); sel FB_BPP-1 is the colour MSB.
    function automatic addr_t byte_addr(xcoord_t x, ycoord_t y, logic [`FB_SEL_BITS-1:0] sel);
        return addr_t'((32'(y) * `FB_WIDTH + 32'(x)) * `FB_BPP + 32'(sel));
    endfunction

endpackage

// File: logic/fill_area.sv
// **********************************************************
// Rectangle fill walker; writes one colour byte per granted
// memory cycle, bottom-right corner first, MSB first.
// **********************************************************
`timescale 1ns/10ps
`include "fb_defines.svh"

module fill_area (
    input  logic              clk,
    input  logic              reset,
    input  logic              fill_start,
    input  fb_pkg::xcoord_t   x1,
    input  fb_pkg::ycoord_t   y1,
    input  fb_pkg::xcoord_t   width,
    input  fb_pkg::ycoord_t   height,
    input  fb_pkg::color_t    color,
    output logic              req,
    output logic              we,
    output fb_pkg::addr_t     addr,
    output logic [7:0]        wdata,
    input  logic              gnt,
    output logic              busy,
    output logic              done
);

    localparam logic [`FB_SEL_BITS-1:0] SEL_LAST = `FB_SEL_BITS'(`FB_BPP - 1);

    fb_pkg::fill_state_t state;

    fb_pkg::xcoord_t         x_lo;
    fb_pkg::xcoord_t         x_hi;                     // Column reload at each new row.
    fb_pkg::ycoord_t         y_lo;
    fb_pkg::color_t          color_q;
    fb_pkg::xcoord_t         col;
    fb_pkg::ycoord_t         row;
    logic [`FB_SEL_BITS-1:0] sel;

    logic last_byte;

    assign last_byte = (sel == '0) && (col == x_lo) && (row == y_lo);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= fb_pkg::FILL_IDLE;
        end else begin
            case (state)
                fb_pkg::FILL_IDLE: begin
                    if (fill_start) begin
                        state <= fb_pkg::FILL_WRITE;
                    end
                end
                fb_pkg::FILL_WRITE: begin
                    if (gnt && last_byte) begin
                        state <= fb_pkg::FILL_DONE;
                    end
                end
                fb_pkg::FILL_DONE: state <= fb_pkg::FILL_IDLE;
                default:           state <= fb_pkg::FILL_IDLE;
            endcase
        end
    end

    // Walk position, only moves on a granted byte.
    always_ff @(posedge clk) begin
        if (state == fb_pkg::FILL_IDLE && fill_start) begin
            x_lo    <= x1;
            y_lo    <= y1;
            x_hi    <= x1 + width - 1'b1;
            color_q <= color;
            col     <= x1 + width - 1'b1;              // Start at the bottom-right corner.
            row     <= y1 + height - 1'b1;
            sel     <= SEL_LAST;
        end else if (state == fb_pkg::FILL_WRITE && gnt) begin
            if (sel != '0) begin
                sel <= sel - 1'b1;
            end else begin
                sel <= SEL_LAST;
                if (col != x_lo) begin
                    col <= col - 1'b1;
                end else begin
                    col <= x_hi;
                    row <= row - 1'b1;
                end
            end
        end
    end

    assign req   = (state == fb_pkg::FILL_WRITE);
    assign we    = req;                                // Fill never reads.
    assign addr  = fb_pkg::byte_addr(col, row, sel);
    assign wdata = color_q[sel*8 +: 8];
    assign busy  = (state != fb_pkg::FILL_IDLE);
    assign done  = (state == fb_pkg::FILL_DONE);

    a_req_held: assert property (@(posedge clk) disable iff (reset)
        req && !gnt |=> req && $stable(addr));

endmodule

// File: logic/frame_ram.sv
// **********************************************************
// Byte-wide single-port frame memory, registered read.
// **********************************************************
`timescale 1ns/10ps
`include "fb_defines.svh"

module frame_ram (
    input  logic              clk,
    input  logic              mem_en,
    input  logic              mem_we,
    input  fb_pkg::addr_t     mem_addr,
    input  logic [7:0]        mem_wdata,
    output logic [7:0]        mem_rdata
);

    logic [7:0] mem [0:`FB_BYTES-1];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end else begin
                mem_rdata <= mem[mem_addr];         // Valid the cycle after the grant.
            end
        end
    end

endmodule

// File: logic/pixel_access.sv
// **********************************************************
// Single-pixel plot and readback with response handshake.
// **********************************************************
`timescale 1ns/10ps
`include "fb_defines.svh"

module pixel_access (
    input  logic              clk,
    input  logic              reset,
    input  logic              pix_start,
    input  logic              pix_write,
    input  fb_pkg::xcoord_t   x,
    input  fb_pkg::ycoord_t   y,
    input  fb_pkg::color_t    color,
    output logic              req,
    output logic              we,
    output fb_pkg::addr_t     addr,
    output logic [7:0]        wdata,
    input  logic              gnt,
    input  logic [7:0]        rdata,
    output logic              busy,
    output logic              rsp_valid,
    output fb_pkg::color_t    rsp_color,
    input  logic              rsp_ready
);

    localparam logic [`FB_SEL_BITS-1:0] SEL_LAST = `FB_SEL_BITS'(`FB_BPP - 1);

    fb_pkg::pix_state_t      state;
    logic                    write_q;
    fb_pkg::xcoord_t         x_q;
    fb_pkg::ycoord_t         y_q;
    fb_pkg::color_t          color_q;
    logic [`FB_SEL_BITS-1:0] sel;
    logic                    cap_en;                   // Read byte arrives this cycle.
    logic [`FB_SEL_BITS-1:0] cap_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= fb_pkg::PIX_IDLE;
            cap_en <= 1'b0;
        end else begin
            cap_en <= gnt && !write_q;
            case (state)
                fb_pkg::PIX_IDLE: begin
                    if (pix_start) begin
                        state <= fb_pkg::PIX_ACCESS;
                    end
                end
                fb_pkg::PIX_ACCESS: begin
                    if (gnt && sel == '0) begin
                        state <= write_q ? fb_pkg::PIX_IDLE : fb_pkg::PIX_WAIT_DATA;
                    end
                end
                fb_pkg::PIX_WAIT_DATA: state <= fb_pkg::PIX_RESPOND;
                fb_pkg::PIX_RESPOND: begin
                    if (rsp_ready) begin
                        state <= fb_pkg::PIX_IDLE;
                    end
                end
                default: state <= fb_pkg::PIX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == fb_pkg::PIX_IDLE && pix_start) begin
            write_q <= pix_write;
            x_q     <= x;
            y_q     <= y;
            color_q <= color;
            sel     <= SEL_LAST;
        end else if (gnt && sel != '0) begin
            sel <= sel - 1'b1;
        end
        cap_sel <= sel;
        if (cap_en) begin
            rsp_color[cap_sel*8 +: 8] <= rdata;        // Assemble from the byte just read.
        end
    end

    assign req       = (state == fb_pkg::PIX_ACCESS);
    assign we        = write_q;
    assign addr      = fb_pkg::byte_addr(x_q, y_q, sel);
    assign wdata     = color_q[sel*8 +: 8];
    assign busy      = (state != fb_pkg::PIX_IDLE);
    assign rsp_valid = (state == fb_pkg::PIX_RESPOND);

endmodule

// File: project.f
+incdir+logic
logic/fb_pkg.sv
logic/frame_ram.sv
logic/fb_arbiter.sv
logic/fill_area.sv
logic/pixel_access.sv
logic/cmd_dispatch.sv
logic/display_engine.sv
testbench/tb_display_engine.sv

// File: testbench/display_cases.txt
# op (0 fill, 1 plot, 2 read), x, y, width, height in decimal, then colour and expected in hex.
# Plots and reads ignore width and height; only reads use the expected colour.
1  0  0  0 0 a1b2c3 000000
2  0  0  0 0 000000 a1b2c3
1 15 11  0 0 010203 000000
2 15 11  0 0 000000 010203
1  3  4  0 0 111111 000000
1  8  4  0 0 222222 000000
1  5  2  0 0 333333 000000
1  5  6  0 0 444444 000000
0  4  3  4 3 00ff80 000000
2  4  3  0 0 000000 00ff80
2  7  5  0 0 000000 00ff80
2  4  5  0 0 000000 00ff80
2  7  3  0 0 000000 00ff80
2  5  4  0 0 000000 00ff80
2  3  4  0 0 000000 111111
2  8  4  0 0 000000 222222
2  5  2  0 0 000000 333333
2  5  6  0 0 000000 444444
0  0  7 16 4 c0ffee 000000
1  2  1  0 0 5a5a5a 000000
1 10 11  0 0 0f0f0f 000000
2  2  1  0 0 000000 5a5a5a
2 10 11  0 0 000000 0f0f0f
2  0  7  0 0 000000 c0ffee
2 15 10  0 0 000000 c0ffee
2 15 11  0 0 000000 010203
2  5  6  0 0 000000 444444
0 12  0  1 1 deadbe 000000
2 12  0  0 0 000000 deadbe
1  0  0  0 0 ffffff 000000
2  0  0  0 0 000000 ffffff

// File: testbench/tb_display_engine.sv
// **********************************************************
// Display engine testbench that replays the cases file and
// checks read responses and fill completions.
// **********************************************************
`timescale 1ns/10ps
`include "fb_defines.svh"

module tb_display_engine;

    localparam string CASES_FILE = "testbench/display_cases.txt";
    localparam int    MAX_CASES  = 64;

    logic              clk;
    logic              reset;
    logic              cmd_valid;
    logic              cmd_ready;
    fb_pkg::opcode_t   cmd_op;
    fb_pkg::xcoord_t   cmd_x;
    fb_pkg::ycoord_t   cmd_y;
    fb_pkg::xcoord_t   cmd_width;
    fb_pkg::ycoord_t   cmd_height;
    fb_pkg::color_t    cmd_color;
    logic              rsp_valid;
    fb_pkg::color_t    rsp_color;
    logic              rsp_ready;
    logic              fill_done;

    fb_pkg::opcode_t   case_op     [MAX_CASES];
    fb_pkg::xcoord_t   case_x      [MAX_CASES];
    fb_pkg::ycoord_t   case_y      [MAX_CASES];
    fb_pkg::xcoord_t   case_w      [MAX_CASES];
    fb_pkg::ycoord_t   case_h      [MAX_CASES];
    fb_pkg::color_t    case_color  [MAX_CASES];
    fb_pkg::color_t    case_expect [MAX_CASES];
    fb_pkg::color_t    expect_q [$];                  // Expected colours of accepted reads.

    int num_cases    = 0;
    int fill_lines   = 0;
    int read_lines   = 0;
    int fill_count   = 0;
    int fills_sent   = 0;                             // Fill commands accepted so far.
    int rsp_count    = 0;
    int limit_cycles = 0;

    display_engine i_dut (
        .clk(clk), .reset(reset),
        .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd_op(cmd_op),
        .cmd_x(cmd_x), .cmd_y(cmd_y), .cmd_width(cmd_width), .cmd_height(cmd_height),
        .cmd_color(cmd_color),
        .rsp_valid(rsp_valid), .rsp_color(rsp_color), .rsp_ready(rsp_ready),
        .fill_done(fill_done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_color(input string name, input fb_pkg::color_t expected,
                               input fb_pkg::color_t actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, got %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic check_done(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("[ERROR] %s count: expected %h, got %h", name, expected, actual);
            $display("TB FAILED");
            $fatal(1, "completion count mismatch");
        end
    endtask

    // Reads every case line and sizes the watchdog from the byte counts.
    task automatic load_cases();
        int             fd;
        int             op, x, y, w, h;
        string          line;
        fb_pkg::color_t color;
        fb_pkg::color_t exp_color;
        fd = $fopen(CASES_FILE, "r");
        if (fd == 0) begin
            report_failure("Could not open the cases file.");
        end else begin
            limit_cycles = 10 + 30;                    // Reset plus the final drain.
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d %d %d %h %h",
                                op, x, y, w, h, color, exp_color) != 7 || op > 2) begin
                        report_failure({"Malformed line in the cases file: ", line});
                    end
                    case_op[num_cases]     = fb_pkg::opcode_t'(op[1:0]);
                    case_x[num_cases]      = fb_pkg::xcoord_t'(x);
                    case_y[num_cases]      = fb_pkg::ycoord_t'(y);
                    case_w[num_cases]      = fb_pkg::xcoord_t'(w);
                    case_h[num_cases]      = fb_pkg::ycoord_t'(h);
                    case_color[num_cases]  = color;
                    case_expect[num_cases] = exp_color;
                    fill_lines += (op == 0) ? 1 : 0;
                    read_lines += (op == 2) ? 1 : 0;
                    limit_cycles += ((op == 0) ? w * h * `FB_BPP : `FB_BPP) * 4 + 50;
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Called 1 ns after a rising edge; returns 1 ns after the accepting edge.
    task automatic send_command(input int idx);
        logic plot_in_fill;
        cmd_op     = case_op[idx];
        cmd_x      = case_x[idx];
        cmd_y      = case_y[idx];
        cmd_width  = case_w[idx];
        cmd_height = case_h[idx];
        cmd_color  = case_color[idx];
        cmd_valid  = 1'b1;
        plot_in_fill = (case_op[idx] == fb_pkg::OP_PLOT) && (fills_sent > fill_count);
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);
        if (plot_in_fill && fill_count == fills_sent) begin
            report_failure("A plot was held back until the running fill had finished.");
        end
        if (cmd_op == fb_pkg::OP_READ) begin
            expect_q.push_back(case_expect[idx]);
        end
        if (cmd_op == fb_pkg::OP_FILL) begin
            fills_sent++;
        end
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(64933));
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd_op     = fb_pkg::OP_FILL;
        cmd_x      = '0;
        cmd_y      = '0;
        cmd_width  = '0;
        cmd_height = '0;
        cmd_color  = '0;
        rsp_ready  = 1'b0;
        load_cases();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < num_cases; i++) begin
            send_command(i);
            repeat ($urandom % 4) begin                // Random idle gap.
                @(posedge clk);
                #1;
            end
        end
        while (rsp_count < read_lines || fill_count < fill_lines) @(posedge clk);
        repeat (20) @(posedge clk);                    // Catch stray pulses or responses.
        check_done("fill_done", fill_lines, fill_count);
        check_done("rsp_valid", read_lines, rsp_count);
        if (expect_q.size() != 0) begin
            report_failure("Some read commands never produced a response.");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            #1;
            rsp_ready = ($urandom % 3) != 0;           // Stall about a third of cycles.
        end
    end

    always @(negedge clk) begin
        if (!reset && fill_done) begin
            fill_count <= fill_count + 1;
        end
    end

    initial begin : collector
        logic           pending;
        fb_pkg::color_t held;
        fb_pkg::color_t want;
        pending = 1'b0;
        forever begin
            @(negedge clk);
            if (pending && !rsp_valid) begin
                report_failure("rsp_valid dropped before rsp_ready was seen.");
            end else if (pending) begin
                check_color("rsp_color (held)", held, rsp_color);
            end
            if (rsp_valid && rsp_ready) begin
                if (expect_q.size() == 0) begin
                    report_failure("A read response arrived with no read outstanding.");
                end else begin
                    want = expect_q.pop_front();
                    check_color("rsp_color", want, rsp_color);
                    rsp_count++;
                end
                pending = 1'b0;
            end else if (rsp_valid) begin
                pending = 1'b1;
                held    = rsp_color;
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("The run timed out after %0d cycles without finishing.", limit_cycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
